/* Bender.yml */
package:
  name: spi_ctrl

sources:
  - hdl/spi_ctrl_pkg.sv
  - hdl/reg_bus_if.sv
  - hdl/axi4lite_slave.sv
  - hdl/spi_ctrl_regs.sv
  - hdl/spi_word_buffer.sv
  - hdl/spi_engine.sv
  - hdl/spi_ctrl_top.sv
  - target: test
    files:
      - tb/spi_ctrl_checker.sv
      - tb/spi_ctrl_tb.sv

/* hdl/axi4lite_slave.sv */
`timescale 1ns/1ps

module axi4lite_slave (
  input  logic                                S_AXI_ACLK,
  input  logic                                S_AXI_ARESETN,
  input  logic [5:0]                          S_AXI_AWADDR,
  input  logic [2:0]                          S_AXI_AWPROT,
  input  logic                                S_AXI_AWVALID,
  output logic                                S_AXI_AWREADY,
  input  logic [spi_ctrl_pkg::data_w-1:0]     S_AXI_WDATA,
  input  logic [spi_ctrl_pkg::data_w/8-1:0]   S_AXI_WSTRB,
  input  logic                                S_AXI_WVALID,
  output logic                                S_AXI_WREADY,
  output logic [1:0]                          S_AXI_BRESP,
  output logic                                S_AXI_BVALID,
  input  logic                                S_AXI_BREADY,
  input  logic [5:0]                          S_AXI_ARADDR,
  input  logic [2:0]                          S_AXI_ARPROT,
  input  logic                                S_AXI_ARVALID,
  output logic                                S_AXI_ARREADY,
  output logic [spi_ctrl_pkg::data_w-1:0]     S_AXI_RDATA,
  output logic [1:0]                          S_AXI_RRESP,
  output logic                                S_AXI_RVALID,
  input  logic                                S_AXI_RREADY,
  reg_bus_if.slave_side                       bus
);
  import spi_ctrl_pkg::*;

  logic              wr_accept;
  logic              rd_accept;
  logic [data_w-1:0] rdata_q;

  // Protection bits are not decoded, every response is OKAY
  assign S_AXI_BRESP = 2'b00;
  assign S_AXI_RRESP = 2'b00;

  ////////////////////
  // Write channel
  ////////////////////

  // Address and data taken together, only with no response pending
  assign wr_accept = !S_AXI_AWREADY && !S_AXI_BVALID && S_AXI_AWVALID && S_AXI_WVALID;

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      S_AXI_AWREADY <= 1'b0;
      S_AXI_WREADY  <= 1'b0;
      S_AXI_BVALID  <= 1'b0;
      bus.wr_en     <= 1'b0;
    end else begin
      S_AXI_AWREADY <= wr_accept;
      S_AXI_WREADY  <= wr_accept;
      // Strobe to the registers one cycle after the handshake
      bus.wr_en     <= S_AXI_AWREADY;
      // Response rises with wr_en, held until the master takes it
      if (S_AXI_AWREADY) begin
        S_AXI_BVALID <= 1'b1;
      end else if (S_AXI_BREADY) begin
        S_AXI_BVALID <= 1'b0;
      end
    end
  end

  // Word index from byte address bits 5:2
  always_ff @(posedge S_AXI_ACLK) begin
    if (S_AXI_AWREADY) begin
      bus.wr_idx  <= S_AXI_AWADDR[5:2];
      bus.wr_data <= S_AXI_WDATA;
      bus.wr_strb <= S_AXI_WSTRB;
    end
  end

  ////////////////////
  // Read channel
  ////////////////////

  assign rd_accept = !S_AXI_ARREADY && !S_AXI_RVALID && S_AXI_ARVALID;

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      S_AXI_ARREADY <= 1'b0;
      S_AXI_RVALID  <= 1'b0;
      bus.rd_en     <= 1'b0;
    end else begin
      S_AXI_ARREADY <= rd_accept;
      bus.rd_en     <= S_AXI_ARREADY;
      if (S_AXI_ARREADY) begin
        S_AXI_RVALID <= 1'b1;
      end else if (S_AXI_RREADY) begin
        S_AXI_RVALID <= 1'b0;
      end
    end
  end

  always_ff @(posedge S_AXI_ACLK) begin
    if (S_AXI_ARREADY) begin
      bus.rd_idx <= S_AXI_ARADDR[5:2];
    end
    // Hold the word, a pop moves the RX pointer right after rd_en
    if (bus.rd_en) begin
      rdata_q <= bus.rd_data;
    end
  end

  // Live value in the rd_en cycle, held copy under back-pressure
  assign S_AXI_RDATA = bus.rd_en ? bus.rd_data : rdata_q;

endmodule

/* hdl/reg_bus_if.sv */
`timescale 1ns/1ps

interface reg_bus_if;
  import spi_ctrl_pkg::*;

  // Write side, one-cycle wr_en with index, data and byte strobes
  reg_idx_t            wr_idx;
  logic [data_w-1:0]   wr_data;
  logic [data_w/8-1:0] wr_strb;
  logic                wr_en;

  // Read side, rd_data is combinational from the register block
  reg_idx_t            rd_idx;
  logic                rd_en;
  logic [data_w-1:0]   rd_data;

  modport slave_side (
    output wr_idx, wr_data, wr_strb, wr_en, rd_idx, rd_en,
    input  rd_data
  );
  modport reg_side (
    input  wr_idx, wr_data, wr_strb, wr_en, rd_idx, rd_en,
    output rd_data
  );

endinterface

/* hdl/spi_ctrl_pkg.sv */
package spi_ctrl_pkg;

  // Register and bus data width
  localparam int data_w = 32;

  // Word index into the register map
  typedef logic [3:0] reg_idx_t;

  // Number of decoded registers, higher indices read zero
  localparam int reg_count = 11;

  ////////////////////
  // Register map, byte address is four times the index
  ////////////////////
  localparam reg_idx_t reg_mem_write           = 4'd0;
  localparam reg_idx_t reg_mem_write_ptr       = 4'd1;
  localparam reg_idx_t reg_mem_write_ptr_reset = 4'd2;
  localparam reg_idx_t reg_mem_read            = 4'd3;
  localparam reg_idx_t reg_mem_read_ptr        = 4'd4;
  localparam reg_idx_t reg_mem_read_ptr_reset  = 4'd5;
  localparam reg_idx_t reg_transaction_count   = 4'd6;
  localparam reg_idx_t reg_spi_len             = 4'd7;
  localparam reg_idx_t reg_spi_strb            = 4'd8;
  localparam reg_idx_t reg_status              = 4'd9;
  localparam reg_idx_t reg_param_mem_depth     = 4'd10;

  // Bit positions inside the status register
  localparam int status_busy    = 0;
  localparam int status_done    = 1;
  localparam int status_len_err = 2;

endpackage

/* hdl/spi_ctrl_regs.sv */
`timescale 1ns/1ps

module spi_ctrl_regs #(
  parameter int mem_depth = 64
) (
  input  logic                              S_AXI_ACLK,
  input  logic                              S_AXI_ARESETN,
  reg_bus_if.reg_side                       bus,
  output logic                              tx_push,
  output logic [spi_ctrl_pkg::data_w-1:0]   tx_wdata,
  output logic                              tx_ptr_clr,
  output logic                              rx_pop,
  output logic                              rx_ptr_clr,
  output logic                              start,
  output logic [spi_ctrl_pkg::data_w-1:0]   spi_len,
  input  logic [$clog2(mem_depth)-1:0]      tx_ptr,
  input  logic [$clog2(mem_depth)-1:0]      rx_ptr,
  input  logic [spi_ctrl_pkg::data_w-1:0]   rx_rdata,
  input  logic                              busy,
  input  logic                              done,
  input  logic                              len_err,
  input  logic [spi_ctrl_pkg::data_w-1:0]   transaction_count
);
  import spi_ctrl_pkg::*;

  logic full_wr;

  // Only full-word writes to a decoded index have any effect
  assign full_wr = bus.wr_en && (&bus.wr_strb) && (bus.wr_idx < reg_idx_t'(reg_count));

  ////////////////////
  // Write decode
  ////////////////////
  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      tx_push    <= 1'b0;
      tx_ptr_clr <= 1'b0;
      rx_ptr_clr <= 1'b0;
      start      <= 1'b0;
      tx_wdata   <= '0;
      spi_len    <= '0;
    end else begin
      // Pulses, one cycle after wr_en
      tx_push    <= full_wr && (bus.wr_idx == reg_mem_write);
      tx_ptr_clr <= full_wr && (bus.wr_idx == reg_mem_write_ptr_reset);
      rx_ptr_clr <= full_wr && (bus.wr_idx == reg_mem_read_ptr_reset);
      start      <= full_wr && (bus.wr_idx == reg_spi_strb);
      // mem_write keeps the last pushed word for readback
      if (full_wr && (bus.wr_idx == reg_mem_write)) begin
        tx_wdata <= bus.wr_data;
      end
      if (full_wr && (bus.wr_idx == reg_spi_len)) begin
        spi_len <= bus.wr_data;
      end
    end
  end

  // Each read of mem_read steps the RX pointer
  assign rx_pop = bus.rd_en && (bus.rd_idx == reg_mem_read);

  ////////////////////
  // Read mux
  ////////////////////
  always_comb begin
    bus.rd_data = '0;
    case (bus.rd_idx)
      reg_mem_write:         bus.rd_data = tx_wdata;
      reg_mem_write_ptr:     bus.rd_data = data_w'(tx_ptr);
      reg_mem_read:          bus.rd_data = rx_rdata;
      reg_mem_read_ptr:      bus.rd_data = data_w'(rx_ptr);
      reg_transaction_count: bus.rd_data = transaction_count;
      reg_spi_len:           bus.rd_data = spi_len;
      reg_status: begin
        bus.rd_data[status_busy]    = busy;
        bus.rd_data[status_done]    = done;
        bus.rd_data[status_len_err] = len_err;
      end
      reg_param_mem_depth:   bus.rd_data = data_w'(mem_depth);
      // Pointer resets, strobe and out-of-range indices read zero
      default:               bus.rd_data = '0;
    endcase
  end

endmodule

/* hdl/spi_ctrl_top.sv */
`timescale 1ns/1ps

module spi_ctrl_top #(
  parameter int mem_depth = 64,
  parameter int clk_div   = 4
) (
  input  logic                                S_AXI_ACLK,
  input  logic                                S_AXI_ARESETN,
  input  logic [5:0]                          S_AXI_AWADDR,
  input  logic [2:0]                          S_AXI_AWPROT,
  input  logic                                S_AXI_AWVALID,
  output logic                                S_AXI_AWREADY,
  input  logic [spi_ctrl_pkg::data_w-1:0]     S_AXI_WDATA,
  input  logic [spi_ctrl_pkg::data_w/8-1:0]   S_AXI_WSTRB,
  input  logic                                S_AXI_WVALID,
  output logic                                S_AXI_WREADY,
  output logic [1:0]                          S_AXI_BRESP,
  output logic                                S_AXI_BVALID,
  input  logic                                S_AXI_BREADY,
  input  logic [5:0]                          S_AXI_ARADDR,
  input  logic [2:0]                          S_AXI_ARPROT,
  input  logic                                S_AXI_ARVALID,
  output logic                                S_AXI_ARREADY,
  output logic [spi_ctrl_pkg::data_w-1:0]     S_AXI_RDATA,
  output logic [1:0]                          S_AXI_RRESP,
  output logic                                S_AXI_RVALID,
  input  logic                                S_AXI_RREADY,
  output logic                                sck,
  output logic                                cs_b,
  output logic                                pico,
  input  logic                                poci
);
  import spi_ctrl_pkg::*;

  localparam int aw = $clog2(mem_depth);

  // Register block to buffers and engine
  logic              tx_push;
  logic [data_w-1:0] tx_wdata;
  logic              tx_ptr_clr;
  logic              rx_pop;
  logic              rx_ptr_clr;
  logic              start;
  logic [data_w-1:0] spi_len;
  logic [aw-1:0]     tx_ptr;
  logic [aw-1:0]     rx_ptr;
  logic [data_w-1:0] rx_rdata;
  // Engine status
  logic              busy;
  logic              done;
  logic              len_err;
  logic [data_w-1:0] transaction_count;
  // Engine to buffers
  logic [aw-1:0]     tx_addr;
  logic [data_w-1:0] tx_rdata;
  logic [aw-1:0]     rx_addr;
  logic [data_w-1:0] rx_wdata;
  logic              rx_we;

  reg_bus_if bus ();

  axi4lite_slave u_axi (
    .S_AXI_ACLK, .S_AXI_ARESETN,
    .S_AXI_AWADDR, .S_AXI_AWPROT, .S_AXI_AWVALID, .S_AXI_AWREADY,
    .S_AXI_WDATA, .S_AXI_WSTRB, .S_AXI_WVALID, .S_AXI_WREADY,
    .S_AXI_BRESP, .S_AXI_BVALID, .S_AXI_BREADY,
    .S_AXI_ARADDR, .S_AXI_ARPROT, .S_AXI_ARVALID, .S_AXI_ARREADY,
    .S_AXI_RDATA, .S_AXI_RRESP, .S_AXI_RVALID, .S_AXI_RREADY,
    .bus (bus.slave_side)
  );

  spi_ctrl_regs #(.mem_depth(mem_depth)) u_regs (
    .S_AXI_ACLK, .S_AXI_ARESETN,
    .bus (bus.reg_side),
    .tx_push, .tx_wdata, .tx_ptr_clr, .rx_pop, .rx_ptr_clr, .start, .spi_len,
    .tx_ptr, .rx_ptr, .rx_rdata, .busy, .done, .len_err, .transaction_count
  );

  // TX side, filled from the bus and read by the engine
  spi_word_buffer #(.mem_depth(mem_depth)) tx_buf (
    .S_AXI_ACLK, .S_AXI_ARESETN,
    .push (tx_push), .pop (1'b0), .clr (tx_ptr_clr),
    .wdata (tx_wdata), .rdata (), .ptr (tx_ptr),
    .eng_addr (tx_addr), .eng_wdata ('0), .eng_we (1'b0), .eng_rdata (tx_rdata)
  );

  // RX side, filled by the engine and drained through mem_read
  spi_word_buffer #(.mem_depth(mem_depth)) rx_buf (
    .S_AXI_ACLK, .S_AXI_ARESETN,
    .push (1'b0), .pop (rx_pop), .clr (rx_ptr_clr),
    .wdata ('0), .rdata (rx_rdata), .ptr (rx_ptr),
    .eng_addr (rx_addr), .eng_wdata (rx_wdata), .eng_we (rx_we), .eng_rdata ()
  );

  spi_engine #(.mem_depth(mem_depth), .clk_div(clk_div)) u_engine (
    .S_AXI_ACLK, .S_AXI_ARESETN,
    .start, .spi_len, .tx_addr, .tx_rdata, .rx_addr, .rx_wdata, .rx_we,
    .busy, .done, .len_err, .transaction_count,
    .sck, .cs_b, .pico, .poci
  );

endmodule

/* hdl/spi_engine.sv */
`timescale 1ns/1ps

module spi_engine #(
  parameter int mem_depth = 64,
  parameter int clk_div   = 4
) (
  input  logic                              S_AXI_ACLK,
  input  logic                              S_AXI_ARESETN,
  input  logic                              start,
  input  logic [spi_ctrl_pkg::data_w-1:0]   spi_len,
  output logic [$clog2(mem_depth)-1:0]      tx_addr,
  input  logic [spi_ctrl_pkg::data_w-1:0]   tx_rdata,
  output logic [$clog2(mem_depth)-1:0]      rx_addr,
  output logic [spi_ctrl_pkg::data_w-1:0]   rx_wdata,
  output logic                              rx_we,
  output logic                              busy,
  output logic                              done,
  output logic                              len_err,
  output logic [spi_ctrl_pkg::data_w-1:0]   transaction_count,
  output logic                              sck,
  output logic                              cs_b,
  output logic                              pico,
  input  logic                              poci
);
  import spi_ctrl_pkg::*;

  localparam int aw    = $clog2(mem_depth);
  localparam int div_w = (clk_div > 1) ? $clog2(clk_div) : 1;
  localparam logic [data_w-1:0] max_len = data_w'(mem_depth * 32);

  // Sequencer states
  localparam logic [1:0] st_idle  = 2'd0;
  localparam logic [1:0] st_setup = 2'd1;
  localparam logic [1:0] st_shift = 2'd2;
  localparam logic [1:0] st_hold  = 2'd3;

  logic [1:0]        state;
  logic [div_w-1:0]  div_cnt;
  logic [aw+4:0]     bit_cnt;
  logic [data_w-1:0] len_q;
  logic [data_w-1:0] rx_shift;
  logic              tick;
  logic              rise;
  logic              fall;
  logic              last_bit;

  // One tick per sck half period
  assign tick     = (state != st_idle) && (div_cnt == div_w'(clk_div - 1));
  assign rise     = tick && !sck && ((state == st_setup) || (state == st_shift));
  assign fall     = tick && sck && (state == st_shift);
  assign last_bit = (data_w'(bit_cnt) == len_q - 1'b1);

  ////////////////////
  // Buffer access
  ////////////////////
  // Word n/32 on both sides, bit 31-(n mod 32) inside it
  assign tx_addr = bit_cnt[aw+4:5];
  assign rx_addr = bit_cnt[aw+4:5];
  assign pico    = ((state == st_setup) || (state == st_shift)) ?
                   tx_rdata[5'd31 - bit_cnt[4:0]] : 1'b0;

  // Store on the falling edge that ends a word or the transfer
  assign rx_we    = fall && ((&bit_cnt[4:0]) || last_bit);
  // Partial word is left-aligned, zeros fill from below
  assign rx_wdata = rx_shift << (5'd31 - bit_cnt[4:0]);

  always_ff @(posedge S_AXI_ACLK) begin
    // Length frozen for the whole transfer
    if (start && (state == st_idle)) begin
      len_q <= spi_len;
    end
    // poci sampled as sck rises
    if (rise) begin
      rx_shift <= {rx_shift[data_w-2:0], poci};
    end
  end

  ////////////////////
  // Sequencer
  ////////////////////
  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      state             <= st_idle;
      div_cnt           <= '0;
      bit_cnt           <= '0;
      sck               <= 1'b0;
      cs_b              <= 1'b1;
      busy              <= 1'b0;
      done              <= 1'b0;
      len_err           <= 1'b0;
      transaction_count <= '0;
    end else begin
      if ((state == st_idle) || tick) begin
        div_cnt <= '0;
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
      case (state)
        st_idle: begin
          // Start while busy never reaches here
          if (start) begin
            if ((spi_len == '0) || (spi_len > max_len)) begin
              len_err <= 1'b1;
            end else begin
              state   <= st_setup;
              bit_cnt <= '0;
              busy    <= 1'b1;
              done    <= 1'b0;
              len_err <= 1'b0;
              cs_b    <= 1'b0;
            end
          end
        end
        st_setup: begin
          // cs_b low for half a period before the first rise
          if (tick) begin
            state <= st_shift;
            sck   <= 1'b1;
          end
        end
        st_shift: begin
          if (tick) begin
            sck <= !sck;
            if (sck && last_bit) begin
              state <= st_hold;
            end else if (sck) begin
              bit_cnt <= bit_cnt + 1'b1;
            end
          end
        end
        default: begin
          // Hold phase after the last fall, then release cs_b
          if (tick) begin
            state             <= st_idle;
            cs_b              <= 1'b1;
            busy              <= 1'b0;
            done              <= 1'b1;
            transaction_count <= transaction_count + 1'b1;
          end
        end
      endcase
    end
  end

endmodule

/* hdl/spi_word_buffer.sv */
`timescale 1ns/1ps

module spi_word_buffer #(
  parameter int mem_depth = 64
) (
  input  logic                              S_AXI_ACLK,
  input  logic                              S_AXI_ARESETN,
  input  logic                              push,
  input  logic                              pop,
  input  logic                              clr,
  input  logic [spi_ctrl_pkg::data_w-1:0]   wdata,
  output logic [spi_ctrl_pkg::data_w-1:0]   rdata,
  output logic [$clog2(mem_depth)-1:0]      ptr,
  input  logic [$clog2(mem_depth)-1:0]      eng_addr,
  input  logic [spi_ctrl_pkg::data_w-1:0]   eng_wdata,
  input  logic                              eng_we,
  output logic [spi_ctrl_pkg::data_w-1:0]   eng_rdata
);
  import spi_ctrl_pkg::*;

  logic [data_w-1:0] mem [mem_depth];

  // Port side writes at the pointer, engine side at its own address
  always_ff @(posedge S_AXI_ACLK) begin
    if (push) begin
      mem[ptr] <= wdata;
    end
    if (eng_we) begin
      mem[eng_addr] <= eng_wdata;
    end
  end

  // Pointer wraps at mem_depth, clear wins over a step
  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      ptr <= '0;
    end else if (clr) begin
      ptr <= '0;
    end else if (push || pop) begin
      if (ptr == ($clog2(mem_depth))'(mem_depth - 1)) begin
        ptr <= '0;
      end else begin
        ptr <= ptr + 1'b1;
      end
    end
  end

  // Both read ports are asynchronous
  assign rdata     = mem[ptr];
  assign eng_rdata = mem[eng_addr];

endmodule

/* sources.f */
hdl/spi_ctrl_pkg.sv
hdl/reg_bus_if.sv
hdl/axi4lite_slave.sv
hdl/spi_ctrl_regs.sv
hdl/spi_word_buffer.sv
hdl/spi_engine.sv
hdl/spi_ctrl_top.sv
tb/spi_ctrl_checker.sv
tb/spi_ctrl_tb.sv

/* tb/spi_ctrl_checker.sv */
`timescale 1ns/1ps

module spi_ctrl_checker #(
  parameter int mem_depth = 64
) (
  input logic                              S_AXI_ACLK,
  input logic                              S_AXI_ARESETN,
  input logic [5:0]                        S_AXI_AWADDR,
  input logic                              S_AXI_AWVALID,
  input logic                              S_AXI_AWREADY,
  input logic [spi_ctrl_pkg::data_w-1:0]   S_AXI_WDATA,
  input logic [3:0]                        S_AXI_WSTRB,
  input logic                              S_AXI_WVALID,
  input logic                              S_AXI_WREADY,
  input logic [1:0]                        S_AXI_BRESP,
  input logic                              S_AXI_BVALID,
  input logic                              S_AXI_BREADY,
  input logic [5:0]                        S_AXI_ARADDR,
  input logic                              S_AXI_ARVALID,
  input logic                              S_AXI_ARREADY,
  input logic [spi_ctrl_pkg::data_w-1:0]   S_AXI_RDATA,
  input logic [1:0]                        S_AXI_RRESP,
  input logic                              S_AXI_RVALID,
  input logic                              S_AXI_RREADY,
  input logic                              sck,
  input logic                              cs_b,
  input logic                              pico,
  input logic                              poci
);
  import spi_ctrl_pkg::*;

  // Reference model of buffers, pointers and registers
  logic [data_w-1:0] tx_mem [mem_depth];
  logic [data_w-1:0] rx_mem [mem_depth];
  int                tx_ptr;
  int                rx_ptr;
  logic [data_w-1:0] last_word;
  logic [data_w-1:0] len_reg;
  logic [data_w-1:0] count;
  logic              busy_m;
  logic              done_m;
  logic              len_err_m;
  // Transfer in flight
  int                act_len;
  int                rise_cnt;
  logic              sck_q;
  logic              cs_q;
  // Read in flight
  reg_idx_t          rd_idx;
  logic              snap_due;
  logic [data_w-1:0] exp_rdata;
  // Tallies
  int                test_errors = 0;
  int                total_errors = 0;
  int                tests_run = 0;
  int                tests_failed = 0;

  function automatic logic [data_w-1:0] expected_read(input reg_idx_t idx);
    logic [data_w-1:0] v;
    v = '0;
    case (idx)
      reg_mem_write:         v = last_word;
      reg_mem_write_ptr:     v = data_w'(tx_ptr);
      reg_mem_read:          v = rx_mem[rx_ptr];
      reg_mem_read_ptr:      v = data_w'(rx_ptr);
      reg_transaction_count: v = count;
      reg_spi_len:           v = len_reg;
      reg_status: begin
        v[status_busy]    = busy_m;
        v[status_done]    = done_m;
        v[status_len_err] = len_err_m;
      end
      reg_param_mem_depth:   v = data_w'(mem_depth);
      default:               v = '0;
    endcase
    return v;
  endfunction

  // Only full-strobe writes to mapped registers change the model
  task automatic apply_write(input reg_idx_t idx, input logic [data_w-1:0] data,
                             input logic [3:0] strb);
    if ((strb == 4'hf) && (idx < reg_count)) begin
      case (idx)
        reg_mem_write: begin
          tx_mem[tx_ptr] = data;
          tx_ptr = (tx_ptr + 1) % mem_depth;
          last_word = data;
        end
        reg_mem_write_ptr_reset: tx_ptr = 0;
        reg_mem_read_ptr_reset:  rx_ptr = 0;
        reg_spi_len:             len_reg = data;
        reg_spi_strb: begin
          // A start during a transfer is dropped
          if (!busy_m) begin
            if ((len_reg == '0) || (len_reg > data_w'(mem_depth * 32))) begin
              len_err_m = 1'b1;
            end else begin
              busy_m    = 1'b1;
              done_m    = 1'b0;
              len_err_m = 1'b0;
              act_len   = len_reg;
              rise_cnt  = 0;
            end
          end
        end
        default: ;
      endcase
    end
  endtask

  ////////////////////
  // Watcher
  ////////////////////
  always @(posedge S_AXI_ACLK) begin
    int n;
    if (!S_AXI_ARESETN) begin
      tx_ptr    = 0;
      rx_ptr    = 0;
      last_word = '0;
      len_reg   = '0;
      count     = '0;
      busy_m    = 1'b0;
      done_m    = 1'b0;
      len_err_m = 1'b0;
      snap_due  = 1'b0;
      exp_rdata = '0;
      for (int i = 0; i < mem_depth; i++) begin
        tx_mem[i] = '0;
        rx_mem[i] = '0;
      end
    end else begin
      // Bit n on rising sck, pico against the TX stream, poci into RX
      if (busy_m && sck && !sck_q) begin
        n = rise_cnt;
        if (pico !== tx_mem[(n / 32) % mem_depth][31 - (n % 32)]) begin
          $display("MISMATCH at %0t: pico bit %0d is %b, expected %b", $time, n, pico,
                   tx_mem[(n / 32) % mem_depth][31 - (n % 32)]);
          test_errors++;
        end
        // Fresh word starts zeroed, so a partial word stays left-aligned
        if ((n % 32) == 0) begin
          rx_mem[(n / 32) % mem_depth] = '0;
        end
        rx_mem[(n / 32) % mem_depth][31 - (n % 32)] = poci;
        rise_cnt++;
      end
      // Chip select release ends the transfer
      if (busy_m && cs_b && !cs_q) begin
        if (rise_cnt != act_len) begin
          $display("MISMATCH at %0t: %0d sck rising edges, expected %0d", $time,
                   rise_cnt, act_len);
          test_errors++;
        end
        busy_m = 1'b0;
        done_m = 1'b1;
        count  = count + 1'b1;
      end
      if (!busy_m && !cs_b && cs_q) begin
        $display("At %0t cs_b went low although no valid transfer was started", $time);
        test_errors++;
      end
      if (S_AXI_AWVALID && S_AXI_AWREADY && S_AXI_WVALID && S_AXI_WREADY) begin
        apply_write(S_AXI_AWADDR[5:2], S_AXI_WDATA, S_AXI_WSTRB);
      end
      // Every write response is OKAY
      if (S_AXI_BVALID && S_AXI_BREADY && (S_AXI_BRESP !== 2'b00)) begin
        $display("MISMATCH at %0t: write response %b, expected 00", $time, S_AXI_BRESP);
        test_errors++;
      end
      // Expected word taken in the cycle the DUT strobes its read
      if (S_AXI_ARVALID && S_AXI_ARREADY) begin
        rd_idx   = S_AXI_ARADDR[5:2];
        snap_due = 1'b1;
      end else if (snap_due) begin
        exp_rdata = expected_read(rd_idx);
        if (rd_idx == reg_mem_read) begin
          rx_ptr = (rx_ptr + 1) % mem_depth;
        end
        snap_due = 1'b0;
      end
      if (S_AXI_RVALID && S_AXI_RREADY) begin
        if ((S_AXI_RDATA !== exp_rdata) || (S_AXI_RRESP !== 2'b00)) begin
          $display("MISMATCH at %0t: register %0d read %h resp %b, expected %h resp 00",
                   $time, rd_idx, S_AXI_RDATA, S_AXI_RRESP, exp_rdata);
          test_errors++;
        end
      end
    end
    sck_q = sck;
    cs_q  = cs_b;
  end

  ////////////////////
  // Reporting
  ////////////////////
  task automatic end_test(input string name);
    tests_run++;
    if (test_errors == 0) begin
      $display("test %0d, %s: ok", tests_run, name);
    end else begin
      $display("test %0d, %s: %0d errors", tests_run, name, test_errors);
      tests_failed++;
    end
    total_errors += test_errors;
    test_errors = 0;
  endtask

  task automatic report_counts();
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total_errors);
  endtask

endmodule

/* tb/spi_ctrl_tb.sv */
`timescale 1ns/1ps

module spi_ctrl_tb;
  import spi_ctrl_pkg::*;

  localparam int mem_depth = 64;
  localparam int clk_div   = 4;
  localparam int max_len   = mem_depth * 32;

  logic              S_AXI_ACLK;
  logic              S_AXI_ARESETN;
  logic [5:0]        S_AXI_AWADDR;
  logic [2:0]        S_AXI_AWPROT;
  logic              S_AXI_AWVALID;
  logic              S_AXI_AWREADY;
  logic [data_w-1:0] S_AXI_WDATA;
  logic [3:0]        S_AXI_WSTRB;
  logic              S_AXI_WVALID;
  logic              S_AXI_WREADY;
  logic [1:0]        S_AXI_BRESP;
  logic              S_AXI_BVALID;
  logic              S_AXI_BREADY;
  logic [5:0]        S_AXI_ARADDR;
  logic [2:0]        S_AXI_ARPROT;
  logic              S_AXI_ARVALID;
  logic              S_AXI_ARREADY;
  logic [data_w-1:0] S_AXI_RDATA;
  logic [1:0]        S_AXI_RRESP;
  logic              S_AXI_RVALID;
  logic              S_AXI_RREADY;
  logic              sck;
  logic              cs_b;
  logic              pico;
  logic              poci;

  // Words the SPI peripheral shifts out on poci, MSB first from word 0
  logic [data_w-1:0] poci_words [mem_depth];
  logic [data_w-1:0] rd_val;
  int                len_a;
  int                len_b;
  int                len_c;
  int                cycle_limit = 2000;
  int                cycles = 0;

  spi_ctrl_top #(.mem_depth(mem_depth), .clk_div(clk_div)) DUT (.*);

  spi_ctrl_checker #(.mem_depth(mem_depth)) u_chk (.*);

  initial begin
    S_AXI_ACLK = 1'b0;
    forever #5 S_AXI_ACLK = ~S_AXI_ACLK;
  end

  // Run limit from the transfer lengths plus room for bus traffic
  always @(posedge S_AXI_ACLK) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("Timeout: the tests did not finish within %0d clock cycles", cycle_limit);
      $display("Result: FAILED");
      $finish;
    end
  end

  ////////////////////
  // Bus tasks
  ////////////////////
  // Inputs change 1 ns after the rising edge
  task automatic step();
    @(posedge S_AXI_ACLK);
    #1;
  endtask

  task automatic bus_write(input reg_idx_t idx, input logic [31:0] data,
                           input logic [3:0] strb);
    S_AXI_AWADDR  = {idx, 2'b00};
    S_AXI_WDATA   = data;
    S_AXI_WSTRB   = strb;
    S_AXI_AWVALID = 1'b1;
    S_AXI_WVALID  = 1'b1;
    do step(); while (!S_AXI_AWREADY);
    // Handshake on the next edge
    step();
    S_AXI_AWVALID = 1'b0;
    S_AXI_WVALID  = 1'b0;
    while (!S_AXI_BVALID) step();
    // Random back-pressure on the response
    repeat ($urandom % 4) step();
    S_AXI_BREADY = 1'b1;
    step();
    S_AXI_BREADY = 1'b0;
  endtask

  task automatic bus_read(input reg_idx_t idx, output logic [31:0] data);
    S_AXI_ARADDR  = {idx, 2'b00};
    S_AXI_ARVALID = 1'b1;
    do step(); while (!S_AXI_ARREADY);
    step();
    S_AXI_ARVALID = 1'b0;
    while (!S_AXI_RVALID) step();
    repeat ($urandom % 4) step();
    S_AXI_RREADY = 1'b1;
    data = S_AXI_RDATA;
    step();
    S_AXI_RREADY = 1'b0;
  endtask

  task automatic push_words(input int n);
    for (int i = 0; i < n; i++) begin
      bus_write(reg_mem_write, $urandom, 4'hf);
    end
  endtask

  // Each RX word followed by the pointer it leaves behind
  task automatic read_back(input int n);
    logic [31:0] v;
    for (int i = 0; i < n; i++) begin
      bus_read(reg_mem_read, v);
      bus_read(reg_mem_read_ptr, v);
    end
  endtask

  task automatic refill_poci();
    for (int i = 0; i < mem_depth; i++) begin
      poci_words[i] = $urandom;
    end
  endtask

  // Start and poll status until busy drops
  task automatic run_transfer(input int len);
    logic [31:0] v;
    bus_write(reg_spi_len, len, 4'hf);
    bus_write(reg_spi_strb, 32'h0, 4'hf);
    do bus_read(reg_status, v); while (v[status_busy]);
  endtask

  ////////////////////
  // SPI peripheral
  ////////////////////
  function automatic logic poci_bit(input int n);
    return poci_words[(n / 32) % mem_depth][31 - (n % 32)];
  endfunction

  // Bit 0 on chip select, next bit after each falling sck
  initial begin
    int bit_idx;
    forever begin
      @(negedge cs_b);
      bit_idx = 0;
      #1 poci = poci_bit(bit_idx);
      while (!cs_b) begin
        @(negedge sck or posedge cs_b);
        if (!cs_b) begin
          bit_idx++;
          #1 poci = poci_bit(bit_idx);
        end
      end
    end
  end

  ////////////////////
  // Test sequence
  ////////////////////
  initial begin
    int n_words;
    void'($urandom(32'h4ef6_f5f8));
    S_AXI_ARESETN = 1'b0;
    S_AXI_AWADDR  = '0;
    S_AXI_AWPROT  = '0;
    S_AXI_AWVALID = 1'b0;
    S_AXI_WDATA   = '0;
    S_AXI_WSTRB   = '0;
    S_AXI_WVALID  = 1'b0;
    S_AXI_BREADY  = 1'b0;
    S_AXI_ARADDR  = '0;
    S_AXI_ARPROT  = '0;
    S_AXI_ARVALID = 1'b0;
    S_AXI_RREADY  = 1'b0;
    poci          = 1'b0;
    len_a = 1 + $urandom % 320;
    len_b = 1 + $urandom % 96;
    len_c = max_len;
    cycle_limit = (len_a + len_b + len_c) * 2 * clk_div + 2000;
    repeat (10) @(posedge S_AXI_ACLK);
    #1 S_AXI_ARESETN = 1'b1;
    step();

    // Readback, partial strobe, parameter and unmapped index
    bus_write(reg_spi_len, $urandom, 4'hf);
    bus_read(reg_spi_len, rd_val);
    bus_write(reg_spi_len, $urandom, 4'h3);
    bus_read(reg_spi_len, rd_val);
    bus_read(reg_param_mem_depth, rd_val);
    bus_write(reg_idx_t'(11 + $urandom % 5), $urandom, 4'hf);
    bus_read(reg_idx_t'(11 + $urandom % 5), rd_val);
    u_chk.end_test("register access");

    // More than mem_depth pushes, pointer wraps
    bus_write(reg_mem_write_ptr_reset, 32'h0, 4'hf);
    n_words = mem_depth + $urandom % 4;
    push_words(n_words);
    bus_read(reg_mem_write_ptr, rd_val);
    bus_read(reg_mem_write, rd_val);
    refill_poci();
    run_transfer(len_a);
    u_chk.end_test("TX buffer and transmit");

    bus_write(reg_mem_read_ptr_reset, 32'h0, 4'hf);
    read_back((len_a + 31) / 32);
    u_chk.end_test("RX buffer and read-back");

    // New words land from word 0 after the TX reset
    bus_read(reg_mem_write_ptr, rd_val);
    bus_write(reg_mem_write_ptr_reset, 32'h0, 4'hf);
    bus_read(reg_mem_write_ptr, rd_val);
    push_words((len_b + 31) / 32);
    refill_poci();
    run_transfer(len_b);
    bus_read(reg_mem_read_ptr, rd_val);
    bus_write(reg_mem_read_ptr_reset, 32'h0, 4'hf);
    bus_read(reg_mem_read_ptr, rd_val);
    read_back((len_b + 31) / 32);
    u_chk.end_test("pointer resets");

    // Longest legal transfer over the whole buffer
    refill_poci();
    run_transfer(len_c);
    bus_read(reg_status, rd_val);
    bus_read(reg_transaction_count, rd_val);
    u_chk.end_test("status and count");

    run_transfer(0);
    bus_read(reg_status, rd_val);
    bus_read(reg_transaction_count, rd_val);
    run_transfer(max_len + 1 + $urandom % 1000);
    bus_read(reg_status, rd_val);
    bus_read(reg_transaction_count, rd_val);
    u_chk.end_test("length errors");

    u_chk.report_counts();
    if (u_chk.total_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule
